// File: all.f
+incdir+hw
hw/hx_pkg.sv
hw/inst_decoder.sv
hw/rename_unit.sv
hw/rs_entry.sv
hw/alu_issue.sv
hw/reorder_buffer.sv
hw/hx_core.sv
verification/hx_core_assert.sv
verification/hx_core_tb.sv

// File: verification/hx_core_tb.sv
`timescale 1ns/100ps

module hx_core_tb import hx_pkg::*; ();

    localparam int ROWS       = 24;
    localparam int CLK_PERIOD = 40;

    logic     clk_i;
    logic     reset_i;
    logic     inst_valid_i;
    inst_t    inst_i;
    logic     stall_o;
    logic     debug_commit_en_o;
    logic     debug_reg_wen_o;
    addr_t    debug_pc_o;
    reg_idx_t debug_reg_id_o;
    word_t    debug_reg_wdata_o;

    // program table with one row per instruction in program order
    inst_t    prog    [ROWS];
    reg_idx_t exp_rd  [ROWS];
    logic     exp_wen [ROWS];
    word_t    exp_val [ROWS];
    logic     no_gap  [ROWS];
    int       rows_added;

    int       commit_idx;
    logic     stall_seen;

    hx_core hx_core_i (
        .clk_i             (clk_i),
        .reset_i           (reset_i),
        .inst_valid_i      (inst_valid_i),
        .inst_i            (inst_i),
        .stall_o           (stall_o),
        .debug_commit_en_o (debug_commit_en_o),
        .debug_reg_wen_o   (debug_reg_wen_o),
        .debug_pc_o        (debug_pc_o),
        .debug_reg_id_o    (debug_reg_id_o),
        .debug_reg_wdata_o (debug_reg_wdata_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    function automatic inst_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3,
                                     input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic inst_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                     input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic add_row(input inst_t inst, input reg_idx_t rd, input logic wen,
                           input word_t val, input logic burst);
        prog[rows_added]    = inst;
        exp_rd[rows_added]  = rd;
        exp_wen[rows_added] = wen;
        exp_val[rows_added] = val;
        no_gap[rows_added]  = burst;
        rows_added++;
    endtask

    // expected values worked out by hand from zeroed registers
    task automatic build_program();
        add_row(i_type(12'h005, 0, 3'b000, 1), 1, 1, 32'h0000_0005, 0);
        add_row(i_type(12'hffd, 0, 3'b000, 2), 2, 1, 32'hffff_fffd, 0);
        add_row(r_type(7'h00, 2, 1, 3'b000, 3), 3, 1, 32'h0000_0002, 0);
        add_row(r_type(7'h20, 2, 1, 3'b000, 4), 4, 1, 32'h0000_0008, 0);
        add_row(r_type(7'h00, 1, 2, 3'b010, 5), 5, 1, 32'h0000_0001, 0);
        add_row(r_type(7'h00, 1, 2, 3'b011, 6), 6, 1, 32'h0000_0000, 0);
        add_row(i_type(12'h0ff, 3, 3'b100, 7), 7, 1, 32'h0000_00fd, 0);
        add_row(i_type(12'h0f0, 7, 3'b111, 8), 8, 1, 32'h0000_00f0, 0);
        add_row(i_type(12'h00f, 8, 3'b110, 9), 9, 1, 32'h0000_00ff, 0);
        // write to x0 is dropped and x0 still reads zero
        add_row(i_type(12'h007, 9, 3'b000, 0), 0, 0, 32'h0000_0000, 0);
        add_row(r_type(7'h00, 9, 0, 3'b000, 10), 10, 1, 32'h0000_00ff, 0);
        // srl is outside the subset so x1 keeps its value
        add_row(r_type(7'h00, 0, 0, 3'b101, 1), 1, 0, 32'h0000_0000, 1);
        // back to back dependent chain on x11
        add_row(i_type(12'h001, 1, 3'b000, 11), 11, 1, 32'h0000_0006, 1);
        add_row(r_type(7'h00, 11, 11, 3'b000, 11), 11, 1, 32'h0000_000c, 1);
        add_row(i_type(12'hffe, 11, 3'b000, 11), 11, 1, 32'h0000_000a, 1);
        add_row(r_type(7'h00, 9, 11, 3'b100, 11), 11, 1, 32'h0000_00f5, 1);
        add_row(r_type(7'h20, 1, 11, 3'b000, 11), 11, 1, 32'h0000_00f0, 1);
        add_row(i_type(12'h100, 11, 3'b010, 12), 12, 1, 32'h0000_0001, 1);
        add_row(r_type(7'h00, 11, 12, 3'b110, 13), 13, 1, 32'h0000_00f1, 1);
        add_row(r_type(7'h00, 13, 13, 3'b000, 14), 14, 1, 32'h0000_01e2, 0);
        add_row(r_type(7'h00, 14, 0, 3'b011, 15), 15, 1, 32'h0000_0001, 0);
        add_row(r_type(7'h00, 7, 14, 3'b111, 16), 16, 1, 32'h0000_00e0, 0);
        add_row(r_type(7'h00, 2, 11, 3'b010, 17), 17, 1, 32'h0000_0000, 0);
        add_row(r_type(7'h20, 1, 0, 3'b000, 18), 18, 1, 32'hffff_fffb, 0);
    endtask

    initial begin
        int unsigned gap;
        clk_i        = 1'b0;
        reset_i      = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        commit_idx   = 0;
        stall_seen   = 1'b0;
        rows_added   = 0;
        void'($urandom(32'h7d12));
        build_program();
        repeat (3) @(negedge clk_i);
        reset_i = 1'b0;
        // nothing stalls or commits before the first instruction
        repeat (2) begin
            @(negedge clk_i);
            check_value("stall_o", stall_o, 0);
            check_value("debug_commit_en_o", debug_commit_en_o, 0);
        end
        for (int r = 0; r < ROWS; r++) begin
            inst_valid_i = 1'b1;
            inst_i       = prog[r];
            while (stall_o) @(negedge clk_i);
            @(negedge clk_i);
            inst_valid_i = 1'b0;
            inst_i       = '0;
            if (!no_gap[r]) begin
                gap = $urandom % 3;
                repeat (gap) @(negedge clk_i);
            end
        end
        wait (commit_idx == ROWS);
        // give a stray extra commit time to show up
        repeat (10) @(negedge clk_i);
        if (stall_seen) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("stall_o never went high during the dependent burst");
            abort_run();
        end
    end

    // commit monitor walks the table in order
    always @(negedge clk_i) begin
        if (!reset_i && debug_commit_en_o === 1'b1) begin
            if (commit_idx >= ROWS) begin
                $display("a commit arrived after every table row had committed");
                abort_run();
            end else begin
                check_value("debug_pc_o", debug_pc_o, commit_idx * 4);
                check_value("debug_reg_id_o", debug_reg_id_o, exp_rd[commit_idx]);
                check_value("debug_reg_wen_o", debug_reg_wen_o, exp_wen[commit_idx]);
                if (exp_wen[commit_idx]) begin
                    check_value("debug_reg_wdata_o", debug_reg_wdata_o, exp_val[commit_idx]);
                end
                commit_idx++;
            end
        end
    end

    always @(negedge clk_i) begin
        if (!reset_i && stall_o === 1'b1) begin
            stall_seen = 1'b1;
        end
        if (hx_core_i.hx_core_assert_i.violations != 0) begin
            $display("an assertion on the core outputs failed");
            abort_run();
        end
    end

    initial begin
        @(negedge reset_i);
        #(ROWS * 20 * CLK_PERIOD);
        $display("the commits did not finish in time, %0d of %0d seen", commit_idx, ROWS);
        abort_run();
    end

endmodule

// File: verification/hx_core_assert.sv
`timescale 1ns/100ps

module hx_core_assert import hx_pkg::*; (
    input logic     clk_i,
    input logic     reset_i,
    input logic     stall_o,
    input logic     debug_commit_en_o,
    input logic     debug_reg_wen_o,
    input reg_idx_t debug_reg_id_o
);

    // number of failed assertions
    int unsigned violations = 0;

    wen_needs_commit: assert property (@(posedge clk_i) disable iff (reset_i)
        debug_reg_wen_o |-> debug_commit_en_o)
    else begin
        $error("register write without a commit");
        violations++;
    end

    no_write_to_x0: assert property (@(posedge clk_i) disable iff (reset_i)
        debug_reg_wen_o |-> debug_reg_id_o != '0)
    else begin
        $error("register write to x0");
        violations++;
    end

    outputs_known: assert property (@(posedge clk_i) disable iff (reset_i)
        !$isunknown(stall_o) && !$isunknown(debug_commit_en_o))
    else begin
        $error("stall or commit strobe is unknown");
        violations++;
    end

endmodule

bind hx_core hx_core_assert hx_core_assert_i (.*);

// File: hw/hx_core.sv
`timescale 1ns/100ps
`include "hx_consts.svh"

module hx_core import hx_pkg::*; (
    input  logic     clk_i,
    input  logic     reset_i,
    input  logic     inst_valid_i,
    input  inst_t    inst_i,
    output logic     stall_o,
    output logic     debug_commit_en_o,
    output logic     debug_reg_wen_o,
    output addr_t    debug_pc_o,
    output reg_idx_t debug_reg_id_o,
    output word_t    debug_reg_wdata_o
);

    reg_idx_t dec_rs1;
    reg_idx_t dec_rs2;
    reg_idx_t dec_rd;
    word_t    dec_imm;
    alu_op_t  dec_alu_op;
    logic     dec_use_imm;
    logic     dec_wr_reg;
    logic     dec_illegal;

    rs_vec_t  rs_write;
    rs_vec_t  rs_busy;
    rs_vec_t  rs_ready;
    rs_vec_t  rs_grant;
    word_t    disp_op1;
    word_t    disp_op2;
    logic     disp_op1_ready;
    logic     disp_op2_ready;
    rrf_tag_t disp_op1_tag;
    rrf_tag_t disp_op2_tag;
    rrf_tag_t disp_dst_tag;
    alu_op_t  disp_alu_op;

    // per-entry payload towards the ALU
    word_t    rs_op1    [`HX_RS_NUM];
    word_t    rs_op2    [`HX_RS_NUM];
    rrf_tag_t rs_dst_tag[`HX_RS_NUM];
    alu_op_t  rs_alu_op [`HX_RS_NUM];

    logic     result_valid;
    rrf_tag_t result_tag;
    word_t    result_data;

    logic     dispatch;
    reg_idx_t dispatch_rd;
    logic     dispatch_wen;
    addr_t    dispatch_pc;

    logic     commit_en;
    rrf_tag_t commit_tag;
    reg_idx_t commit_rd;
    logic     commit_wen;

    assign debug_commit_en_o = commit_en;
    assign debug_reg_wen_o   = commit_wen;
    assign debug_reg_id_o    = commit_rd;

    inst_decoder inst_decoder_i (
        .inst_i    (inst_i),
        .rs1_o     (dec_rs1),
        .rs2_o     (dec_rs2),
        .rd_o      (dec_rd),
        .imm_o     (dec_imm),
        .alu_op_o  (dec_alu_op),
        .use_imm_o (dec_use_imm),
        .wr_reg_o  (dec_wr_reg),
        .illegal_o (dec_illegal)
    );

    rename_unit rename_unit_i (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .inst_valid_i   (inst_valid_i),
        .rs1_i          (dec_rs1),
        .rs2_i          (dec_rs2),
        .rd_i           (dec_rd),
        .imm_i          (dec_imm),
        .alu_op_i       (dec_alu_op),
        .use_imm_i      (dec_use_imm),
        .wr_reg_i       (dec_wr_reg),
        .illegal_i      (dec_illegal),
        .rs_busy_i      (rs_busy),
        .result_valid_i (result_valid),
        .result_tag_i   (result_tag),
        .result_data_i  (result_data),
        .commit_en_i    (commit_en),
        .commit_tag_i   (commit_tag),
        .commit_rd_i    (commit_rd),
        .commit_wen_i   (commit_wen),
        .stall_o        (stall_o),
        .rs_write_o     (rs_write),
        .op1_o          (disp_op1),
        .op2_o          (disp_op2),
        .op1_ready_o    (disp_op1_ready),
        .op2_ready_o    (disp_op2_ready),
        .op1_tag_o      (disp_op1_tag),
        .op2_tag_o      (disp_op2_tag),
        .dst_tag_o      (disp_dst_tag),
        .alu_op_o       (disp_alu_op),
        .dispatch_o     (dispatch),
        .dispatch_rd_o  (dispatch_rd),
        .dispatch_wen_o (dispatch_wen),
        .dispatch_pc_o  (dispatch_pc),
        .commit_data_o  (debug_reg_wdata_o)
    );

    for (genvar i = 0; i < `HX_RS_NUM; i++) begin : g_rs
        rs_entry rs_entry_i (
            .clk_i          (clk_i),
            .reset_i        (reset_i),
            .write_i        (rs_write[i]),
            .grant_i        (rs_grant[i]),
            .op1_i          (disp_op1),
            .op1_ready_i    (disp_op1_ready),
            .op1_tag_i      (disp_op1_tag),
            .op2_i          (disp_op2),
            .op2_ready_i    (disp_op2_ready),
            .op2_tag_i      (disp_op2_tag),
            .dst_tag_i      (disp_dst_tag),
            .alu_op_i       (disp_alu_op),
            .result_valid_i (result_valid),
            .result_tag_i   (result_tag),
            .result_data_i  (result_data),
            .busy_o         (rs_busy[i]),
            .ready_o        (rs_ready[i]),
            .op1_o          (rs_op1[i]),
            .op2_o          (rs_op2[i]),
            .dst_tag_o      (rs_dst_tag[i]),
            .alu_op_o       (rs_alu_op[i])
        );
    end

    alu_issue alu_issue_i (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .ready_i        (rs_ready),
        .op1_i          (rs_op1),
        .op2_i          (rs_op2),
        .dst_tag_i      (rs_dst_tag),
        .alu_op_i       (rs_alu_op),
        .grant_o        (rs_grant),
        .result_valid_o (result_valid),
        .result_tag_o   (result_tag),
        .result_data_o  (result_data)
    );

    reorder_buffer reorder_buffer_i (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .dispatch_i     (dispatch),
        .dispatch_tag_i (disp_dst_tag),
        .dispatch_rd_i  (dispatch_rd),
        .dispatch_wen_i (dispatch_wen),
        .dispatch_pc_i  (dispatch_pc),
        .result_valid_i (result_valid),
        .result_tag_i   (result_tag),
        .commit_en_o    (commit_en),
        .commit_tag_o   (commit_tag),
        .commit_rd_o    (commit_rd),
        .commit_wen_o   (commit_wen),
        .commit_pc_o    (debug_pc_o)
    );

endmodule

// File: hw/reorder_buffer.sv
`timescale 1ns/100ps
`include "hx_consts.svh"

module reorder_buffer import hx_pkg::*; (
    input  logic     clk_i,
    input  logic     reset_i,
    input  logic     dispatch_i,
    input  rrf_tag_t dispatch_tag_i,
    input  reg_idx_t dispatch_rd_i,
    input  logic     dispatch_wen_i,
    input  addr_t    dispatch_pc_i,
    input  logic     result_valid_i,
    input  rrf_tag_t result_tag_i,
    output logic     commit_en_o,
    output rrf_tag_t commit_tag_o,
    output reg_idx_t commit_rd_o,
    output logic     commit_wen_o,
    output addr_t    commit_pc_o
);

    logic [`HX_RRF_NUM-1:0] finished;
    rrf_tag_t               commit_ptr;
    reg_idx_t               slot_rd  [`HX_RRF_NUM];
    logic                   slot_wen [`HX_RRF_NUM];
    addr_t                  slot_pc  [`HX_RRF_NUM];

    // oldest slot retires once its result is in
    assign commit_en_o  = finished[commit_ptr];
    assign commit_tag_o = commit_ptr;
    assign commit_rd_o  = slot_rd[commit_ptr];
    assign commit_wen_o = commit_en_o && slot_wen[commit_ptr];
    assign commit_pc_o  = slot_pc[commit_ptr];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            finished   <= '0;
            commit_ptr <= '0;
        end else begin
            if (commit_en_o) begin
                finished[commit_ptr] <= 1'b0;
                commit_ptr           <= commit_ptr + 1'b1;
            end
            if (result_valid_i) begin
                finished[result_tag_i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (dispatch_i) begin
            slot_rd[dispatch_tag_i]  <= dispatch_rd_i;
            slot_wen[dispatch_tag_i] <= dispatch_wen_i;
            slot_pc[dispatch_tag_i]  <= dispatch_pc_i;
        end
    end

endmodule

// File: hw/alu_issue.sv
`timescale 1ns/100ps
`include "hx_consts.svh"

module alu_issue import hx_pkg::*; (
    input  logic     clk_i,
    input  logic     reset_i,
    input  rs_vec_t  ready_i,
    input  word_t    op1_i     [`HX_RS_NUM],
    input  word_t    op2_i     [`HX_RS_NUM],
    input  rrf_tag_t dst_tag_i [`HX_RS_NUM],
    input  alu_op_t  alu_op_i  [`HX_RS_NUM],
    output rs_vec_t  grant_o,
    output logic     result_valid_o,
    output rrf_tag_t result_tag_o,
    output word_t    result_data_o
);

    word_t    sel_op1;
    word_t    sel_op2;
    rrf_tag_t sel_tag;
    alu_op_t  sel_op;
    word_t    alu_out;

    // lowest ready entry wins
    assign grant_o = ready_i & (~ready_i + 1'b1);

    always_comb begin
        sel_op1 = '0;
        sel_op2 = '0;
        sel_tag = '0;
        sel_op  = `HX_ALU_ADD;
        for (int i = 0; i < `HX_RS_NUM; i++) begin
            if (grant_o[i]) begin
                sel_op1 = op1_i[i];
                sel_op2 = op2_i[i];
                sel_tag = dst_tag_i[i];
                sel_op  = alu_op_i[i];
            end
        end
    end

    always_comb begin
        case (sel_op)
            `HX_ALU_ADD:  alu_out = sel_op1 + sel_op2;
            `HX_ALU_SUB:  alu_out = sel_op1 - sel_op2;
            `HX_ALU_AND:  alu_out = sel_op1 & sel_op2;
            `HX_ALU_OR:   alu_out = sel_op1 | sel_op2;
            `HX_ALU_XOR:  alu_out = sel_op1 ^ sel_op2;
            `HX_ALU_SLT:  alu_out = word_t'($signed(sel_op1) < $signed(sel_op2));
            `HX_ALU_SLTU: alu_out = word_t'(sel_op1 < sel_op2);
            default:      alu_out = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            result_valid_o <= 1'b0;
        end else begin
            result_valid_o <= |ready_i;
        end
    end

    always_ff @(posedge clk_i) begin
        result_tag_o  <= sel_tag;
        result_data_o <= alu_out;
    end

endmodule

// File: hw/rs_entry.sv
`timescale 1ns/100ps

module rs_entry import hx_pkg::*; (
    input  logic     clk_i,
    input  logic     reset_i,
    input  logic     write_i,
    input  logic     grant_i,
    input  word_t    op1_i,
    input  logic     op1_ready_i,
    input  rrf_tag_t op1_tag_i,
    input  word_t    op2_i,
    input  logic     op2_ready_i,
    input  rrf_tag_t op2_tag_i,
    input  rrf_tag_t dst_tag_i,
    input  alu_op_t  alu_op_i,
    input  logic     result_valid_i,
    input  rrf_tag_t result_tag_i,
    input  word_t    result_data_i,
    output logic     busy_o,
    output logic     ready_o,
    output word_t    op1_o,
    output word_t    op2_o,
    output rrf_tag_t dst_tag_o,
    output alu_op_t  alu_op_o
);

    logic     op1_rdy;
    logic     op2_rdy;
    rrf_tag_t op1_tag;
    rrf_tag_t op2_tag;

    assign ready_o = busy_o && op1_rdy && op2_rdy;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy_o <= 1'b0;
        end else if (write_i) begin
            busy_o <= 1'b1;
        end else if (grant_i) begin
            busy_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (write_i) begin
            op1_o     <= op1_i;
            op1_rdy   <= op1_ready_i;
            op1_tag   <= op1_tag_i;
            op2_o     <= op2_i;
            op2_rdy   <= op2_ready_i;
            op2_tag   <= op2_tag_i;
            dst_tag_o <= dst_tag_i;
            alu_op_o  <= alu_op_i;
        end else if (busy_o && result_valid_i) begin
            // wakeup on a matching broadcast
            if (!op1_rdy && op1_tag == result_tag_i) begin
                op1_o   <= result_data_i;
                op1_rdy <= 1'b1;
            end
            if (!op2_rdy && op2_tag == result_tag_i) begin
                op2_o   <= result_data_i;
                op2_rdy <= 1'b1;
            end
        end
    end

endmodule

// File: hw/rename_unit.sv
`timescale 1ns/100ps
`include "hx_consts.svh"

module rename_unit import hx_pkg::*; (
    input  logic     clk_i,
    input  logic     reset_i,
    input  logic     inst_valid_i,
    input  reg_idx_t rs1_i,
    input  reg_idx_t rs2_i,
    input  reg_idx_t rd_i,
    input  word_t    imm_i,
    input  alu_op_t  alu_op_i,
    input  logic     use_imm_i,
    input  logic     wr_reg_i,
    input  logic     illegal_i,
    input  rs_vec_t  rs_busy_i,
    input  logic     result_valid_i,
    input  rrf_tag_t result_tag_i,
    input  word_t    result_data_i,
    input  logic     commit_en_i,
    input  rrf_tag_t commit_tag_i,
    input  reg_idx_t commit_rd_i,
    input  logic     commit_wen_i,
    output logic     stall_o,
    output rs_vec_t  rs_write_o,
    output word_t    op1_o,
    output word_t    op2_o,
    output logic     op1_ready_o,
    output logic     op2_ready_o,
    output rrf_tag_t op1_tag_o,
    output rrf_tag_t op2_tag_o,
    output rrf_tag_t dst_tag_o,
    output alu_op_t  alu_op_o,
    output logic     dispatch_o,
    output reg_idx_t dispatch_rd_o,
    output logic     dispatch_wen_o,
    output addr_t    dispatch_pc_o,
    output word_t    commit_data_o
);

    word_t                   arf      [`HX_REG_NUM];
    rrf_tag_t                arf_tag  [`HX_REG_NUM];
    logic [`HX_REG_NUM-1:0]  busy;
    word_t                   rrf_data [`HX_RRF_NUM];
    logic [`HX_RRF_NUM-1:0]  rrf_valid;
    rrf_tag_t                alloc_ptr;
    logic [$clog2(`HX_RRF_NUM):0] used_cnt;
    addr_t                   pc;
    rs_vec_t                 rs_free;
    logic                    accept;

    // operand source in order of x0, ARF, RRF and same-cycle broadcast
    function automatic void read_src(input reg_idx_t idx, output word_t val,
                                     output logic rdy);
        rrf_tag_t t;
        t   = arf_tag[idx];
        val = '0;
        rdy = 1'b1;
        if (idx == '0) begin
            val = '0;
        end else if (!busy[idx]) begin
            val = arf[idx];
        end else if (rrf_valid[t]) begin
            val = rrf_data[t];
        end else if (result_valid_i && result_tag_i == t) begin
            val = result_data_i;
        end else begin
            rdy = 1'b0;
        end
    endfunction

    assign stall_o = (used_cnt == `HX_RRF_NUM) || (&rs_busy_i);
    assign accept  = inst_valid_i && !stall_o;

    // lowest free entry
    assign rs_free    = ~rs_busy_i;
    assign rs_write_o = accept ? (rs_free & (~rs_free + 1'b1)) : '0;

    always_comb begin
        read_src(rs1_i, op1_o, op1_ready_o);
        read_src(rs2_i, op2_o, op2_ready_o);
        if (illegal_i) begin
            // passes through as a no-op with nothing to wait on
            op1_o       = '0;
            op1_ready_o = 1'b1;
            op2_o       = '0;
            op2_ready_o = 1'b1;
        end else if (use_imm_i) begin
            op2_o       = imm_i;
            op2_ready_o = 1'b1;
        end
    end

    assign op1_tag_o      = arf_tag[rs1_i];
    assign op2_tag_o      = arf_tag[rs2_i];
    assign dst_tag_o      = alloc_ptr;
    assign alu_op_o       = alu_op_i;
    assign dispatch_o     = accept;
    assign dispatch_rd_o  = rd_i;
    assign dispatch_wen_o = wr_reg_i;
    assign dispatch_pc_o  = pc;
    assign commit_data_o  = rrf_data[commit_tag_i];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy      <= '0;
            rrf_valid <= '0;
            alloc_ptr <= '0;
            used_cnt  <= '0;
            pc        <= '0;
        end else begin
            // commit frees the register only if no younger rename took it
            if (commit_en_i && commit_wen_i && arf_tag[commit_rd_i] == commit_tag_i) begin
                busy[commit_rd_i] <= 1'b0;
            end
            if (accept && wr_reg_i) begin
                busy[rd_i] <= 1'b1;
            end
            if (result_valid_i) begin
                rrf_valid[result_tag_i] <= 1'b1;
            end
            if (accept) begin
                rrf_valid[alloc_ptr] <= 1'b0;
                alloc_ptr            <= alloc_ptr + 1'b1;
                pc                   <= pc + 32'd4;
            end
            if (accept && !commit_en_i) begin
                used_cnt <= used_cnt + 1'b1;
            end else if (!accept && commit_en_i) begin
                used_cnt <= used_cnt - 1'b1;
            end
        end
    end

    // architectural registers start at zero
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < `HX_REG_NUM; i++) begin
                arf[i] <= '0;
            end
        end else if (commit_en_i && commit_wen_i) begin
            arf[commit_rd_i] <= rrf_data[commit_tag_i];
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept && wr_reg_i) begin
            arf_tag[rd_i] <= alloc_ptr;
        end
        if (result_valid_i) begin
            rrf_data[result_tag_i] <= result_data_i;
        end
    end

endmodule

// File: hw/inst_decoder.sv
`timescale 1ns/100ps
`include "hx_consts.svh"

module inst_decoder import hx_pkg::*; (
    input  inst_t    inst_i,
    output reg_idx_t rs1_o,
    output reg_idx_t rs2_o,
    output reg_idx_t rd_o,
    output word_t    imm_o,
    output alu_op_t  alu_op_o,
    output logic     use_imm_o,
    output logic     wr_reg_o,
    output logic     illegal_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    assign rs1_o = inst_i[19:15];
    assign rs2_o = inst_i[24:20];
    assign rd_o  = inst_i[11:7];

    // sign-extended I-type immediate
    assign imm_o = {{20{inst_i[31]}}, inst_i[31:20]};

    always_comb begin
        alu_op_o  = `HX_ALU_ADD;
        use_imm_o = 1'b0;
        illegal_o = 1'b1;
        case (opcode)
            `HX_OPC_OP: begin
                if (funct7 == `HX_F7_BASE) begin
                    illegal_o = 1'b0;
                    case (funct3)
                        `HX_F3_ADD:  alu_op_o = `HX_ALU_ADD;
                        `HX_F3_SLT:  alu_op_o = `HX_ALU_SLT;
                        `HX_F3_SLTU: alu_op_o = `HX_ALU_SLTU;
                        `HX_F3_XOR:  alu_op_o = `HX_ALU_XOR;
                        `HX_F3_OR:   alu_op_o = `HX_ALU_OR;
                        `HX_F3_AND:  alu_op_o = `HX_ALU_AND;
                        default:     illegal_o = 1'b1;
                    endcase
                end else if (funct7 == `HX_F7_SUB && funct3 == `HX_F3_ADD) begin
                    illegal_o = 1'b0;
                    alu_op_o  = `HX_ALU_SUB;
                end
            end
            `HX_OPC_OP_IMM: begin
                use_imm_o = 1'b1;
                illegal_o = 1'b0;
                case (funct3)
                    `HX_F3_ADD: alu_op_o = `HX_ALU_ADD;
                    `HX_F3_SLT: alu_op_o = `HX_ALU_SLT;
                    `HX_F3_XOR: alu_op_o = `HX_ALU_XOR;
                    `HX_F3_OR:  alu_op_o = `HX_ALU_OR;
                    `HX_F3_AND: alu_op_o = `HX_ALU_AND;
                    // shifts and sltiu are outside the subset
                    default:    illegal_o = 1'b1;
                endcase
            end
            default: illegal_o = 1'b1;
        endcase
    end

    assign wr_reg_o = !illegal_o && (rd_o != '0);

endmodule

// File: hw/hx_pkg.sv
`include "hx_consts.svh"

package hx_pkg;

    // data value, operand or immediate
    typedef logic [`HX_XLEN-1:0] word_t;

    typedef logic [31:0] inst_t;
    typedef logic [31:0] addr_t;

    typedef logic [$clog2(`HX_REG_NUM)-1:0] reg_idx_t;

    // rename tag that doubles as the reorder buffer slot
    typedef logic [$clog2(`HX_RRF_NUM)-1:0] rrf_tag_t;

    typedef logic [`HX_ALU_OP_W-1:0] alu_op_t;

    // one bit per reservation station entry
    typedef logic [`HX_RS_NUM-1:0] rs_vec_t;

endpackage

// File: hw/hx_consts.svh
`ifndef HX_CONSTS_SVH
`define HX_CONSTS_SVH

`define HX_XLEN      32
`define HX_REG_NUM   32
`define HX_RRF_NUM   8
`define HX_RS_NUM    4
`define HX_ALU_OP_W  4

// major opcodes
`define HX_OPC_OP      7'b0110011
`define HX_OPC_OP_IMM  7'b0010011

`define HX_F3_ADD   3'b000
`define HX_F3_SLT   3'b010
`define HX_F3_SLTU  3'b011
`define HX_F3_XOR   3'b100
`define HX_F3_OR    3'b110
`define HX_F3_AND   3'b111

`define HX_F7_BASE  7'b0000000
`define HX_F7_SUB   7'b0100000

`define HX_ALU_ADD   4'd0
`define HX_ALU_SUB   4'd1
`define HX_ALU_AND   4'd2
`define HX_ALU_OR    4'd3
`define HX_ALU_XOR   4'd4
`define HX_ALU_SLT   4'd5
`define HX_ALU_SLTU  4'd6

`endif
